// ==== testbench/ising_trace.txt ====
# op addr data tag, numbers in hex; MW/MR memory write/read, RW/RR register write/read
# WS waits until status bit <addr> equals <data>; MR and RR compare against <data>
MW a 5a5a1234 mem_idle_wr
MR a 5a5a1234 mem_idle_rd
# Ferromagnetic couplings of +1, zero diagonal, zero bias
MW 0 11111110 ferro_row0
MW 1 11111101 ferro_row1
MW 2 11111011 ferro_row2
MW 3 11110111 ferro_row3
MW 4 11101111 ferro_row4
MW 5 11011111 ferro_row5
MW 6 10111111 ferro_row6
MW 7 01111111 ferro_row7
MW 8 00000000 ferro_bias
RW 0 1 load_mode
MW a deadbeef load_host_wr
WS 0 1 load_done
RW 0 0 idle_mode
MR a 5a5a1234 load_mem_kept
# Five up, three down settles to all up in two sweeps
RW 1 1f ferro_init
RW 0 2 compute_mode
WS 1 1 ferro_done
RR 2 207 ferro_status
RR 3 ff ferro_result
RW 0 0 idle_mode
MR 9 ff ferro_mem
# Three up, five down settles to all down
RW 1 07 ferro_init2
RW 0 2 compute_mode
WS 1 0 done_cleared
WS 1 1 ferro_done2
RR 2 207 ferro_status2
RR 3 0 ferro_result2
RW 0 0 idle_mode
MR 9 0 ferro_mem2
# Spins 0 and 1 coupled by -1, the rest free, flips every sweep
MW 0 000000f0 osc_row0
MW 1 0000000f osc_row1
MW 2 00000000 osc_row2
MW 3 00000000 osc_row3
MW 4 00000000 osc_row4
MW 5 00000000 osc_row5
MW 6 00000000 osc_row6
MW 7 00000000 osc_row7
MW 8 00000000 osc_bias
RW 0 1 load_mode2
WS 0 1 load_done2
RW 0 0 idle_mode
RW 1 a3 osc_init
RW 0 2 compute_mode
WS 1 1 osc_done
RR 2 1003 osc_status
RR 3 a3 osc_result
RW 0 0 idle_mode
MR 9 a3 osc_mem

// ==== files.f ====
source/ising_pkg.sv
source/l1_memory.sv
source/reg_interface.sv
source/weight_loader.sv
source/spin_compute.sv
source/spin_array_model.sv
source/ising_core.sv
testbench/ising_core_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the Ising core testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal --top-module ising_core_tb -f files.f -o ising_sim
build_status=$?
if [ "$build_status" -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit "$build_status"
fi

./obj_dir/ising_sim
sim_status=$?
if [ "$sim_status" -ne 0 ]; then
    echo "Simulation failed with status $sim_status"
fi

exit "$sim_status"

// ==== testbench/ising_core_tb.sv ====
/*
 * Ising core testbench
 * Replays memory and register operations from a trace file and
 * checks read data and status against the values in the trace
 */

`timescale 1ns/1ps
`default_nettype none

module ising_core_tb;

    localparam int WAIT_LIMIT = 200;
    // Trace opcodes, two characters each
    localparam logic [15:0] OP_MEM_WR  = "MW";
    localparam logic [15:0] OP_MEM_RD  = "MR";
    localparam logic [15:0] OP_REG_WR  = "RW";
    localparam logic [15:0] OP_REG_RD  = "RR";
    localparam logic [15:0] OP_WAIT_ST = "WS";
    // A lone # token starts a comment line
    localparam logic [15:0] OP_NOTE    = 16'h0023;

    logic                                clk_i;
    logic                                reset_i;
    logic                                mem_we_i;
    logic                                mem_re_i;
    logic [ising_pkg::MEM_AW-1:0]        mem_addr_i;
    logic [ising_pkg::WORD_W-1:0]        mem_wdata_i;
    logic [ising_pkg::WORD_W-1:0]        mem_rdata_o;
    logic                                mem_rvalid_o;
    logic                                reg_we_i;
    logic [ising_pkg::REG_AW-1:0]        reg_addr_i;
    logic [ising_pkg::WORD_W-1:0]        reg_wdata_i;
    logic [ising_pkg::WORD_W-1:0]        reg_rdata_o;

    // Trace parsing
    int                                  fd;
    int                                  n;
    int                                  ops;
    int                                  gap;
    logic [8*96-1:0]                     line;
    logic [15:0]                         op;
    logic [31:0]                         arg_a;
    logic [31:0]                         arg_b;
    logic [8*16-1:0]                     tag;

    ising_core DUT (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .mem_we_i    (mem_we_i),
        .mem_re_i    (mem_re_i),
        .mem_addr_i  (mem_addr_i),
        .mem_wdata_i (mem_wdata_i),
        .mem_rdata_o (mem_rdata_o),
        .mem_rvalid_o(mem_rvalid_o),
        .reg_we_i    (reg_we_i),
        .reg_addr_i  (reg_addr_i),
        .reg_wdata_i (reg_wdata_i),
        .reg_rdata_o (reg_rdata_o)
    );

    // 4 ns clock
    initial clk_i = 1'b0;
    always #2 clk_i = ~clk_i;

    //////////////////////////////////////////////////////////////////////
    // Failure and compare
    //////////////////////////////////////////////////////////////////////
    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("tests failed");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_value(input logic [8*16-1:0] name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERR %0s expected %08h actual %08h", name, expected, actual);
            fail_run("read data differs from the trace");
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Host port operations, driven on the rising edge
    //////////////////////////////////////////////////////////////////////
    task automatic mem_write(input logic [ising_pkg::MEM_AW-1:0] addr,
                             input logic [31:0] data);
        @(posedge clk_i);
        mem_we_i    <= 1'b1;
        mem_addr_i  <= addr;
        mem_wdata_i <= data;
        @(posedge clk_i);
        mem_we_i    <= 1'b0;
    endtask

    task automatic mem_read(input logic [ising_pkg::MEM_AW-1:0] addr,
                            input logic [31:0] expected, input logic [8*16-1:0] name);
        int cycles;
        cycles = 0;
        @(posedge clk_i);
        mem_re_i   <= 1'b1;
        mem_addr_i <= addr;
        @(posedge clk_i);
        mem_re_i   <= 1'b0;
        // Read data lands with rvalid
        @(negedge clk_i);
        while (!mem_rvalid_o && cycles < WAIT_LIMIT) begin
            @(negedge clk_i);
            cycles++;
        end
        if (!mem_rvalid_o) begin
            fail_run("memory read never returned rvalid");
        end else begin
            check_value(name, expected, mem_rdata_o);
        end
    endtask

    task automatic reg_write(input logic [ising_pkg::REG_AW-1:0] addr,
                             input logic [31:0] data);
        @(posedge clk_i);
        reg_we_i    <= 1'b1;
        reg_addr_i  <= addr;
        reg_wdata_i <= data;
        @(posedge clk_i);
        reg_we_i    <= 1'b0;
    endtask

    // Read data is combinational, sampled mid-cycle
    task automatic reg_read(input logic [ising_pkg::REG_AW-1:0] addr,
                            input logic [31:0] expected, input logic [8*16-1:0] name);
        @(posedge clk_i);
        reg_addr_i <= addr;
        @(negedge clk_i);
        check_value(name, expected, reg_rdata_o);
    endtask

    task automatic wait_status(input int bit_idx, input logic value);
        int cycles;
        cycles = 0;
        @(posedge clk_i);
        reg_addr_i <= ising_pkg::REG_STATUS;
        @(negedge clk_i);
        while (reg_rdata_o[bit_idx] !== value && cycles < WAIT_LIMIT) begin
            @(negedge clk_i);
            cycles++;
        end
        if (reg_rdata_o[bit_idx] !== value) begin
            fail_run("timed out waiting for a status bit");
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Trace replay
    //////////////////////////////////////////////////////////////////////
    initial begin
        void'($urandom(89));
        ops         = 0;
        reset_i     = 1'b1;
        mem_we_i    = 1'b0;
        mem_re_i    = 1'b0;
        mem_addr_i  = '0;
        mem_wdata_i = '0;
        reg_we_i    = 1'b0;
        reg_addr_i  = '0;
        reg_wdata_i = '0;
        repeat (3) @(posedge clk_i);
        reset_i <= 1'b0;

        fd = $fopen("testbench/ising_trace.txt", "r");
        if (fd == 0) begin
            fail_run("cannot open testbench/ising_trace.txt");
        end else begin
            while (!$feof(fd)) begin
                line = '0;
                n = $fgets(line, fd);
                op = '0;
                tag = '0;
                if (n > 0) begin
                    n = $sscanf(line, "%s %h %h %s", op, arg_a, arg_b, tag);
                end
                if (n > 0 && op != OP_NOTE) begin
                    if (n != 4) begin
                        fail_run("malformed line in the trace file");
                    end else begin
                        // Random idle gap between operations
                        gap = $urandom % 3;
                        repeat (gap) @(posedge clk_i);
                        ops++;
                        case (op)
                            OP_MEM_WR:  mem_write(arg_a[3:0], arg_b);
                            OP_MEM_RD:  mem_read(arg_a[3:0], arg_b, tag);
                            OP_REG_WR:  reg_write(arg_a[1:0], arg_b);
                            OP_REG_RD:  reg_read(arg_a[1:0], arg_b, tag);
                            OP_WAIT_ST: wait_status(int'(arg_a[4:0]), arg_b[0]);
                            default:    fail_run("unknown operation in the trace file");
                        endcase
                    end
                end
            end
            $fclose(fd);
        end

        if (ops == 0) begin
            fail_run("trace file held no operations");
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== source/ising_core.sv ====
/*
 * Ising core top level
 * Local memory, register file, weight loader, compute sequencer
 * and spin array, with the direct memory port routed by mode
 */

`timescale 1ns/1ps
`default_nettype none

module ising_core (
    input  logic                          clk_i,
    input  logic                          reset_i,
    // Host memory port
    input  logic                          mem_we_i,
    input  logic                          mem_re_i,
    input  logic [ising_pkg::MEM_AW-1:0]  mem_addr_i,
    input  logic [ising_pkg::WORD_W-1:0]  mem_wdata_i,
    output logic [ising_pkg::WORD_W-1:0]  mem_rdata_o,
    output logic                          mem_rvalid_o,
    // Host register port
    input  logic                          reg_we_i,
    input  logic [ising_pkg::REG_AW-1:0]  reg_addr_i,
    input  logic [ising_pkg::WORD_W-1:0]  reg_wdata_i,
    output logic [ising_pkg::WORD_W-1:0]  reg_rdata_o
);

    logic [1:0]                     mode;
    logic                           host_en;
    logic [ising_pkg::NUM_SPIN-1:0] spin_init;
    // Direct port at the memory
    logic                           drt_re;
    logic                           drt_we;
    logic [ising_pkg::MEM_AW-1:0]   drt_addr;
    logic [ising_pkg::WORD_W-1:0]   drt_wdata;
    logic [ising_pkg::WORD_W-1:0]   drt_rdata;
    // Loader side
    logic                           ld_re;
    logic [ising_pkg::MEM_AW-1:0]   ld_addr;
    logic [ising_pkg::WORD_W-1:0]   ld_rdata;
    logic                           load_done;
    // Sequencer side
    logic                           cp_we;
    logic [ising_pkg::MEM_AW-1:0]   cp_addr;
    logic [ising_pkg::WORD_W-1:0]   cp_wdata;
    logic                           compute_done;
    logic                           converged;
    logic [ising_pkg::CNT_W-1:0]    sweep_cnt;
    logic [ising_pkg::NUM_SPIN-1:0] result;
    // Array pins
    logic                           arr_wen;
    logic [ising_pkg::MEM_AW-1:0]   arr_waddr;
    logic [ising_pkg::WORD_W-1:0]   arr_wdata;
    logic                           arr_spin_wen;
    logic [ising_pkg::NUM_SPIN-1:0] arr_wr_spin;
    logic                           arr_compute_en;
    logic                           arr_spin_vld;
    logic                           arr_spin_rdy;
    logic [ising_pkg::NUM_SPIN-1:0] arr_spin;

    // Host memory access only in idle, code 3 included
    assign host_en = (mode != ising_pkg::MODE_LOAD) && (mode != ising_pkg::MODE_COMPUTE);

    //////////////////////////////////////////////////////////////////////
    // Memory and registers
    //////////////////////////////////////////////////////////////////////
    l1_memory i_l1_memory (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .host_we_i    (mem_we_i),
        .host_re_i    (mem_re_i),
        .host_addr_i  (mem_addr_i),
        .host_wdata_i (mem_wdata_i),
        .host_rdata_o (mem_rdata_o),
        .host_rvalid_o(mem_rvalid_o),
        .drt_we_i     (drt_we),
        .drt_re_i     (drt_re),
        .drt_addr_i   (drt_addr),
        .drt_wdata_i  (drt_wdata),
        .drt_rdata_o  (drt_rdata),
        .host_en_i    (host_en)
    );

    reg_interface i_reg_interface (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .reg_we_i      (reg_we_i),
        .reg_addr_i    (reg_addr_i),
        .reg_wdata_i   (reg_wdata_i),
        .reg_rdata_o   (reg_rdata_o),
        .mode_o        (mode),
        .spin_init_o   (spin_init),
        .load_done_i   (load_done),
        .compute_done_i(compute_done),
        .converged_i   (converged),
        .sweep_cnt_i   (sweep_cnt),
        .result_i      (result)
    );

    //////////////////////////////////////////////////////////////////////
    // Loader, sequencer and array
    //////////////////////////////////////////////////////////////////////
    weight_loader i_weight_loader (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .mode_i     (mode),
        .drt_re_o   (ld_re),
        .drt_addr_o (ld_addr),
        .drt_rdata_i(ld_rdata),
        .wen_o      (arr_wen),
        .waddr_o    (arr_waddr),
        .wdata_o    (arr_wdata),
        .load_done_o(load_done)
    );

    spin_compute i_spin_compute (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .mode_i        (mode),
        .spin_init_i   (spin_init),
        .spin_wen_o    (arr_spin_wen),
        .wr_spin_o     (arr_wr_spin),
        .compute_en_o  (arr_compute_en),
        .rd_spin_vld_i (arr_spin_vld),
        .rd_spin_rdy_o (arr_spin_rdy),
        .rd_spin_i     (arr_spin),
        .drt_we_o      (cp_we),
        .drt_addr_o    (cp_addr),
        .drt_wdata_o   (cp_wdata),
        .compute_done_o(compute_done),
        .converged_o   (converged),
        .sweep_cnt_o   (sweep_cnt),
        .result_o      (result)
    );

    spin_array_model i_spin_array (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .wen_i        (arr_wen),
        .waddr_i      (arr_waddr),
        .wdata_i      (arr_wdata),
        .spin_wen_i   (arr_spin_wen),
        .wr_spin_i    (arr_wr_spin),
        .compute_en_i (arr_compute_en),
        .rd_spin_vld_o(arr_spin_vld),
        .rd_spin_rdy_i(arr_spin_rdy),
        .rd_spin_o    (arr_spin)
    );

    // Direct port router, owner picked by mode
    always_comb begin
        drt_re    = 1'b0;
        drt_we    = 1'b0;
        drt_addr  = '0;
        drt_wdata = '0;
        ld_rdata  = '0;
        case (mode)
            ising_pkg::MODE_LOAD: begin
                drt_re   = ld_re;
                drt_addr = ld_addr;
                ld_rdata = drt_rdata;
            end
            ising_pkg::MODE_COMPUTE: begin
                drt_we    = cp_we;
                drt_addr  = cp_addr;
                drt_wdata = cp_wdata;
            end
            // Idle and code 3, port parked
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/spin_array_model.sv ====
/*
 * Behavioral spin array
 * Holds couplings, biases and spins; one parallel sign update per
 * compute_en through a two-stage pipeline, result held until taken
 */

`timescale 1ns/1ps
`default_nettype none

module spin_array_model (
    input  logic                            clk_i,
    input  logic                            reset_i,
    // Weight writes from the loader
    input  logic                            wen_i,
    input  logic [ising_pkg::MEM_AW-1:0]    waddr_i,
    input  logic [ising_pkg::WORD_W-1:0]    wdata_i,
    // Spin writes and sweep start
    input  logic                            spin_wen_i,
    input  logic [ising_pkg::NUM_SPIN-1:0]  wr_spin_i,
    input  logic                            compute_en_i,
    // Spin read-out
    output logic                            rd_spin_vld_o,
    input  logic                            rd_spin_rdy_i,
    output logic [ising_pkg::NUM_SPIN-1:0]  rd_spin_o
);

    ising_pkg::row_u                       j_rows_q [ising_pkg::NUM_SPIN];
    ising_pkg::row_u                       h_row_q;
    logic signed [ising_pkg::BIT_H-1:0]    bias [ising_pkg::NUM_SPIN];
    logic signed [ising_pkg::FIELD_W-1:0]  field_d [ising_pkg::NUM_SPIN];
    logic signed [ising_pkg::FIELD_W-1:0]  field_q [ising_pkg::NUM_SPIN];
    logic                                  s1_vld_q;

    // Local field h_i + sum_j J_ij * s_j, with s_j of +1 or -1
    always_comb begin
        for (int i = 0; i < ising_pkg::NUM_SPIN; i++) begin
            bias[i]    = h_row_q.field[i];
            field_d[i] = ising_pkg::FIELD_W'(bias[i]);
            for (int j = 0; j < ising_pkg::NUM_SPIN; j++) begin
                if (rd_spin_o[j]) begin
                    field_d[i] = field_d[i]
                               + ising_pkg::FIELD_W'($signed(j_rows_q[i].field[j]));
                end else begin
                    field_d[i] = field_d[i]
                               - ising_pkg::FIELD_W'($signed(j_rows_q[i].field[j]));
                end
            end
        end
    end

    // Weights, field stage and spins
    always_ff @(posedge clk_i) begin
        if (wen_i) begin
            if (waddr_i == ising_pkg::H_ROW_ADDR) begin
                h_row_q.raw <= wdata_i;
            end else if (waddr_i < ising_pkg::MEM_AW'(ising_pkg::NUM_SPIN)) begin
                j_rows_q[waddr_i[2:0]].raw <= wdata_i;
            end
        end
        if (compute_en_i) begin
            field_q <= field_d;
        end
        if (spin_wen_i) begin
            rd_spin_o <= wr_spin_i;
        end else if (s1_vld_q) begin
            // Sign rule, zero field keeps the old spin
            for (int i = 0; i < ising_pkg::NUM_SPIN; i++) begin
                if (field_q[i][ising_pkg::FIELD_W-1]) begin
                    rd_spin_o[i] <= 1'b0;
                end else if (|field_q[i]) begin
                    rd_spin_o[i] <= 1'b1;
                end
            end
        end
    end

    // Pipeline valid and output handshake
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            s1_vld_q      <= 1'b0;
            rd_spin_vld_o <= 1'b0;
        end else begin
            s1_vld_q <= compute_en_i;
            if (s1_vld_q) begin
                rd_spin_vld_o <= 1'b1;
            end else if (rd_spin_rdy_i) begin
                rd_spin_vld_o <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/spin_compute.sv ====
/*
 * Compute sequencer
 * Writes the initial spins, runs sweeps until the spins settle or
 * the sweep limit, then stores the result in local memory
 */

`timescale 1ns/1ps
`default_nettype none

module spin_compute (
    input  logic                            clk_i,
    input  logic                            reset_i,
    input  logic [1:0]                      mode_i,
    input  logic [ising_pkg::NUM_SPIN-1:0]  spin_init_i,
    // Spin array pins
    output logic                            spin_wen_o,
    output logic [ising_pkg::NUM_SPIN-1:0]  wr_spin_o,
    output logic                            compute_en_o,
    input  logic                            rd_spin_vld_i,
    output logic                            rd_spin_rdy_o,
    input  logic [ising_pkg::NUM_SPIN-1:0]  rd_spin_i,
    // Direct memory write for the result
    output logic                            drt_we_o,
    output logic [ising_pkg::MEM_AW-1:0]    drt_addr_o,
    output logic [ising_pkg::WORD_W-1:0]    drt_wdata_o,
    // Status
    output logic                            compute_done_o,
    output logic                            converged_o,
    output logic [ising_pkg::CNT_W-1:0]     sweep_cnt_o,
    output logic [ising_pkg::NUM_SPIN-1:0]  result_o
);

    logic                           in_comp;
    logic                           comp_start;
    logic [1:0]                     mode_prev_q;
    logic [ising_pkg::SEQ_W-1:0]    state_q;
    logic [ising_pkg::NUM_SPIN-1:0] cur_spin_q;
    logic                           take;

    assign in_comp    = (mode_i == ising_pkg::MODE_COMPUTE);
    assign comp_start = in_comp && (mode_prev_q != ising_pkg::MODE_COMPUTE);
    // Handshake with the array
    assign take       = rd_spin_vld_i && rd_spin_rdy_o;

    // FSM and status
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            mode_prev_q    <= ising_pkg::MODE_IDLE;
            state_q        <= ising_pkg::SEQ_IDLE;
            cur_spin_q     <= '0;
            sweep_cnt_o    <= '0;
            converged_o    <= 1'b0;
            compute_done_o <= 1'b0;
            result_o       <= '0;
        end else begin
            mode_prev_q <= mode_i;
            if (comp_start) begin
                state_q        <= ising_pkg::SEQ_WRITE;
                sweep_cnt_o    <= '0;
                converged_o    <= 1'b0;
                compute_done_o <= 1'b0;
            end else if (!in_comp) begin
                state_q <= ising_pkg::SEQ_IDLE;
            end else begin
                case (state_q)
                    ising_pkg::SEQ_WRITE: begin
                        cur_spin_q <= spin_init_i;
                        state_q    <= ising_pkg::SEQ_START;
                    end
                    ising_pkg::SEQ_START: begin
                        sweep_cnt_o <= sweep_cnt_o + 1'b1;
                        state_q     <= ising_pkg::SEQ_WAIT;
                    end
                    ising_pkg::SEQ_WAIT: begin
                        if (take) begin
                            cur_spin_q <= rd_spin_i;
                            // No spin flipped, fixed point reached
                            if (rd_spin_i == cur_spin_q) begin
                                converged_o <= 1'b1;
                                state_q     <= ising_pkg::SEQ_WBACK;
                            end else if (sweep_cnt_o ==
                                         ising_pkg::CNT_W'(ising_pkg::MAX_SWEEPS)) begin
                                state_q <= ising_pkg::SEQ_WBACK;
                            end else begin
                                state_q <= ising_pkg::SEQ_START;
                            end
                        end
                    end
                    ising_pkg::SEQ_WBACK: begin
                        result_o       <= cur_spin_q;
                        compute_done_o <= 1'b1;
                        state_q        <= ising_pkg::SEQ_DONE;
                    end
                    // Done and idle hold until the mode changes
                    default: ;
                endcase
            end
        end
    end

    // Array pins, decoded from the state
    assign spin_wen_o    = (state_q == ising_pkg::SEQ_WRITE);
    assign wr_spin_o     = spin_init_i;
    assign compute_en_o  = (state_q == ising_pkg::SEQ_START);
    assign rd_spin_rdy_o = (state_q == ising_pkg::SEQ_WAIT);

    // Result write-back
    assign drt_we_o    = (state_q == ising_pkg::SEQ_WBACK);
    assign drt_addr_o  = ising_pkg::RESULT_ADDR;
    assign drt_wdata_o = ising_pkg::WORD_W'(cur_spin_q);

endmodule

`default_nettype wire

// ==== source/weight_loader.sv ====
/*
 * Weight loader
 * On entry into load mode, reads rows 0 to 8 from local memory and
 * writes each into the spin array as it returns
 */

`timescale 1ns/1ps
`default_nettype none

module weight_loader (
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  logic [1:0]                    mode_i,
    // Direct memory port
    output logic                          drt_re_o,
    output logic [ising_pkg::MEM_AW-1:0]  drt_addr_o,
    input  logic [ising_pkg::WORD_W-1:0]  drt_rdata_i,
    // Spin array write pins
    output logic                          wen_o,
    output logic [ising_pkg::MEM_AW-1:0]  waddr_o,
    output logic [ising_pkg::WORD_W-1:0]  wdata_o,
    output logic                          load_done_o
);

    logic                         in_load;
    logic                         load_start;
    logic [1:0]                   mode_prev_q;
    logic                         busy_q;
    logic [ising_pkg::MEM_AW-1:0] rd_addr_q;
    logic                         wen_q;
    logic [ising_pkg::MEM_AW-1:0] waddr_q;

    assign in_load    = (mode_i == ising_pkg::MODE_LOAD);
    // Rising edge of load mode
    assign load_start = in_load && (mode_prev_q != ising_pkg::MODE_LOAD);

    //////////////////////////////////////////////////////////////////////
    // Read side, one row per cycle
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            mode_prev_q <= ising_pkg::MODE_IDLE;
            busy_q      <= 1'b0;
            rd_addr_q   <= '0;
            wen_q       <= 1'b0;
            load_done_o <= 1'b0;
        end else begin
            mode_prev_q <= mode_i;
            // Write strobe trails the read by one cycle
            wen_q       <= busy_q && in_load;
            if (load_start) begin
                busy_q      <= 1'b1;
                rd_addr_q   <= '0;
                load_done_o <= 1'b0;
            end else if (!in_load) begin
                // Mode left early, sequence dropped
                busy_q <= 1'b0;
            end else if (busy_q) begin
                rd_addr_q <= rd_addr_q + 1'b1;
                if (rd_addr_q == ising_pkg::H_ROW_ADDR) begin
                    busy_q <= 1'b0;
                end
            end
            // Bias row written, so the whole matrix is in
            if (wen_q && in_load && waddr_q == ising_pkg::H_ROW_ADDR) begin
                load_done_o <= 1'b1;
            end
        end
    end

    // Address of the row in flight
    always_ff @(posedge clk_i) begin
        waddr_q <= rd_addr_q;
    end

    assign drt_re_o   = busy_q;
    assign drt_addr_o = rd_addr_q;

    // Write side, data straight from the memory read register
    assign wen_o   = wen_q;
    assign waddr_o = waddr_q;
    assign wdata_o = drt_rdata_i;

endmodule

`default_nettype wire

// ==== source/reg_interface.sv ====
/*
 * Host register file
 * Mode and initial-spin registers, read-only status and result
 */

`timescale 1ns/1ps
`default_nettype none

module reg_interface (
    input  logic                            clk_i,
    input  logic                            reset_i,
    // Host register port
    input  logic                            reg_we_i,
    input  logic [ising_pkg::REG_AW-1:0]    reg_addr_i,
    input  logic [ising_pkg::WORD_W-1:0]    reg_wdata_i,
    output logic [ising_pkg::WORD_W-1:0]    reg_rdata_o,
    // To the core
    output logic [1:0]                      mode_o,
    output logic [ising_pkg::NUM_SPIN-1:0]  spin_init_o,
    // Status sources
    input  logic                            load_done_i,
    input  logic                            compute_done_i,
    input  logic                            converged_i,
    input  logic [ising_pkg::CNT_W-1:0]     sweep_cnt_i,
    input  logic [ising_pkg::NUM_SPIN-1:0]  result_i
);

    logic [ising_pkg::WORD_W-1:0] status;

    // Writable registers
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            mode_o      <= ising_pkg::MODE_IDLE;
            spin_init_o <= '0;
        end else if (reg_we_i) begin
            case (reg_addr_i)
                ising_pkg::REG_MODE:      mode_o      <= reg_wdata_i[1:0];
                ising_pkg::REG_SPIN_INIT: spin_init_o <= reg_wdata_i[ising_pkg::NUM_SPIN-1:0];
                // Status and result ignore writes
                default: ;
            endcase
        end
    end

    // Status word, unused bits zero
    always_comb begin
        status = '0;
        status[ising_pkg::ST_LOAD_DONE] = load_done_i;
        status[ising_pkg::ST_COMP_DONE] = compute_done_i;
        status[ising_pkg::ST_CONVERGED] = converged_i;
        status[ising_pkg::ST_CNT_LSB +: ising_pkg::CNT_W] = sweep_cnt_i;
    end

    // Combinational read mux
    always_comb begin
        reg_rdata_o = '0;
        case (reg_addr_i)
            ising_pkg::REG_MODE:      reg_rdata_o[1:0] = mode_o;
            ising_pkg::REG_SPIN_INIT: reg_rdata_o[ising_pkg::NUM_SPIN-1:0] = spin_init_o;
            ising_pkg::REG_STATUS:    reg_rdata_o = status;
            default:                  reg_rdata_o[ising_pkg::NUM_SPIN-1:0] = result_i;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/l1_memory.sv ====
/*
 * Local L1 word memory
 * 16 words with a host port and a direct port for the core,
 * registered reads on both, host port enabled in idle mode only
 */

`timescale 1ns/1ps
`default_nettype none

module l1_memory (
    input  logic                          clk_i,
    input  logic                          reset_i,
    // Host side
    input  logic                          host_we_i,
    input  logic                          host_re_i,
    input  logic [ising_pkg::MEM_AW-1:0]  host_addr_i,
    input  logic [ising_pkg::WORD_W-1:0]  host_wdata_i,
    output logic [ising_pkg::WORD_W-1:0]  host_rdata_o,
    output logic                          host_rvalid_o,
    // Direct side, driven by the mode router
    input  logic                          drt_we_i,
    input  logic                          drt_re_i,
    input  logic [ising_pkg::MEM_AW-1:0]  drt_addr_i,
    input  logic [ising_pkg::WORD_W-1:0]  drt_wdata_i,
    output logic [ising_pkg::WORD_W-1:0]  drt_rdata_o,
    // High in idle mode
    input  logic                          host_en_i
);

    logic [ising_pkg::WORD_W-1:0] mem_q [2**ising_pkg::MEM_AW];
    logic                         host_wr;
    logic                         host_rd;

    // Host requests outside idle are dropped
    assign host_wr = host_en_i & host_we_i;
    assign host_rd = host_en_i & host_re_i;

    // Storage and read data registers
    always_ff @(posedge clk_i) begin
        if (drt_we_i) begin
            mem_q[drt_addr_i] <= drt_wdata_i;
        end
        // Host write last, so it wins on a clash
        if (host_wr) begin
            mem_q[host_addr_i] <= host_wdata_i;
        end
        if (host_rd) begin
            host_rdata_o <= mem_q[host_addr_i];
        end
        if (drt_re_i) begin
            drt_rdata_o <= mem_q[drt_addr_i];
        end
    end

    // Host read valid, one cycle behind the strobe
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            host_rvalid_o <= 1'b0;
        end else begin
            host_rvalid_o <= host_rd;
        end
    end

endmodule

`default_nettype wire

// ==== source/ising_pkg.sv ====
/*
 * Ising core shared definitions
 * Sizes, memory map, register map, mode codes, status layout,
 * sequencer state codes and the coupling-row word view
 */

`default_nettype none

package ising_pkg;

    // Array size and weight precision
    localparam int NUM_SPIN = 8;
    localparam int BIT_J    = 4;
    localparam int BIT_H    = 4;
    // Local field range is 8 * 8 + 8, so 8 bits signed is enough
    localparam int FIELD_W  = 8;

    // Local memory map
    localparam int          WORD_W      = 32;
    localparam int          MEM_AW      = 4;
    localparam logic [3:0]  H_ROW_ADDR  = 4'd8;
    localparam logic [3:0]  RESULT_ADDR = 4'd9;

    // Sweep limit and counter width
    localparam int MAX_SWEEPS = 16;
    localparam int CNT_W      = 5;

    // Mode codes, 3 behaves as idle
    localparam logic [1:0] MODE_IDLE    = 2'd0;
    localparam logic [1:0] MODE_LOAD    = 2'd1;
    localparam logic [1:0] MODE_COMPUTE = 2'd2;

    // Register map
    localparam int         REG_AW        = 2;
    localparam logic [1:0] REG_MODE      = 2'd0;
    localparam logic [1:0] REG_SPIN_INIT = 2'd1;
    localparam logic [1:0] REG_STATUS    = 2'd2;
    localparam logic [1:0] REG_RESULT    = 2'd3;

    // Status word bit positions
    localparam int ST_LOAD_DONE = 0;
    localparam int ST_COMP_DONE = 1;
    localparam int ST_CONVERGED = 2;
    localparam int ST_CNT_LSB   = 8;

    // Compute sequencer state codes
    localparam int         SEQ_W       = 3;
    localparam logic [2:0] SEQ_IDLE    = 3'd0;
    localparam logic [2:0] SEQ_WRITE   = 3'd1;
    localparam logic [2:0] SEQ_START   = 3'd2;
    localparam logic [2:0] SEQ_WAIT    = 3'd3;
    localparam logic [2:0] SEQ_WBACK   = 3'd4;
    localparam logic [2:0] SEQ_DONE    = 3'd5;

    // One memory row, raw or as eight 4-bit signed coefficients
    typedef union packed {
        logic [WORD_W-1:0]                raw;
        logic [NUM_SPIN-1:0][BIT_J-1:0]   field;
    } row_u;

endpackage

`default_nettype wire
